//--- compile.f
+incdir+tb
design/bus_pkg.sv
design/mem_pkg.sv
design/mem_delay_timer.sv
design/sram_slave.sv
design/bus_arbiter.sv
design/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_mem_subsystem -o sim_mem_subsystem

# tee keeps the log even when the simulation exits with an error
./obj_dir/sim_mem_subsystem 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

//--- tb/tb_bus_tasks.svh
// Only strobe bits 0 to 3 select byte lanes
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [7:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
        end
    end
    return result;
endfunction

task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                          input logic [7:0] strb);
    @(posedge clk);
    mem_awvalid <= 1'b1;
    mem_wvalid  <= 1'b1;
    mem_awaddr  <= addr;
    mem_wdata   <= data;
    mem_wstrb   <= strb;
    mem_bready  <= 1'b1;
    req_count++;
    @(negedge clk);
    while (!mem_awready) @(negedge clk);
    check_value("mem_wready", 32'd1, 32'(mem_wready));     // Pulses with awready
    @(posedge clk);
    mem_awvalid <= 1'b0;
    mem_wvalid  <= 1'b0;
    @(negedge clk);
    while (!mem_bvalid) @(negedge clk);
    wr_resp_time = $time;
    if (addr[31:10] == mem_base_page) begin
        shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, strb);
    end
    @(posedge clk);
    mem_bready <= 1'b0;
endtask

task automatic read_word(input bit from_ifu, input logic [31:0] addr, input int hold);
    logic [31:0] expected;
    expected = (addr[31:10] == mem_base_page) ? shadow[addr[9:2]] : mem_unmapped_data;
    @(posedge clk);
    if (from_ifu) begin
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
    end else begin
        mem_arvalid <= 1'b1;
        mem_araddr  <= addr;
    end
    req_count++;
    fork
        begin
            @(negedge clk);
            while (!(from_ifu ? ifu_arready : mem_arready)) @(negedge clk);
            @(posedge clk);
            if (from_ifu) ifu_arvalid <= 1'b0;
            else          mem_arvalid <= 1'b0;
        end
        begin
            repeat (hold) @(posedge clk);       // rready held low for a while
            if (from_ifu) ifu_rready <= 1'b1;
            else          mem_rready <= 1'b1;
        end
    join
    @(negedge clk);
    while (!(from_ifu ? ifu_rvalid : mem_rvalid)) @(negedge clk);
    if (from_ifu) begin
        ifu_resp_time = $time;
        check_value("ifu_rdata", expected, ifu_rdata);
    end else begin
        check_value("mem_rdata", expected, mem_rdata);
    end
    @(posedge clk);
    if (from_ifu) ifu_rready <= 1'b0;
    else          mem_rready <= 1'b0;
endtask

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsystem;
    import bus_pkg::*;
    import mem_pkg::*;

    localparam int num_random       = 40;
    localparam int num_transactions = num_random + 13;
    localparam int clk_period       = 20;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   ifu_arvalid = 1'b0;
    logic                   ifu_rready = 1'b0;
    logic [bus_addr_w-1:0]  ifu_araddr = '0;
    logic                   mem_awvalid = 1'b0;
    logic [bus_addr_w-1:0]  mem_awaddr = '0;
    logic                   mem_wvalid = 1'b0;
    logic [bus_data_w-1:0]  mem_wdata = '0;
    logic [bus_strb_w-1:0]  mem_wstrb = '0;
    logic                   mem_bready = 1'b0;
    logic                   mem_arvalid = 1'b0;
    logic [bus_addr_w-1:0]  mem_araddr = '0;
    logic                   mem_rready = 1'b0;
    wire                    ifu_arready;
    wire                    ifu_rvalid;
    wire                    mem_awready;
    wire                    mem_wready;
    wire                    mem_bvalid;
    wire                    mem_arready;
    wire                    mem_rvalid;
    wire [bus_data_w-1:0]   ifu_rdata;
    wire [bus_data_w-1:0]   mem_rdata;
    wire [arb_state_w-1:0]  arbiter_state;

    logic [bus_data_w-1:0]  shadow [mem_words] = '{default: '0};  // Predicted memory
    int                     req_count = 0;
    int                     resp_count = 0;
    time                    ifu_resp_time = 0;
    time                    wr_resp_time = 0;
    time                    ifu_state_time = 0;
    time                    wr_state_time = 0;

    mem_subsystem_top UUT (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail, %0t, %s, expected %h, got %h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    function automatic logic [31:0] mapped_addr(input logic [7:0] idx);
        return {mem_base_page, idx, 2'b00};
    endfunction

    function automatic logic [31:0] unmapped_addr(input logic [7:0] idx);
        return {22'h10_0000, idx, 2'b00};       // Page of 0x4000_0000
    endfunction

    `include "tb_bus_tasks.svh"

    // Response valids reach the masters as one cycle pulses
    assert property (@(posedge clk) disable iff (rst) $past(ifu_rvalid) |-> !ifu_rvalid)
        else report_mismatch("ifu_rvalid", 32'd0, 32'd1);
    assert property (@(posedge clk) disable iff (rst) $past(mem_rvalid) |-> !mem_rvalid)
        else report_mismatch("mem_rvalid", 32'd0, 32'd1);
    assert property (@(posedge clk) disable iff (rst) $past(mem_bvalid) |-> !mem_bvalid)
        else report_mismatch("mem_bvalid", 32'd0, 32'd1);

    always @(posedge clk) begin
        if (!rst) begin
            resp_count += int'(ifu_rvalid) + int'(mem_rvalid) + int'(mem_bvalid);
        end
    end

    always @(negedge clk) begin                 // First cycle of each owner state
        if (arbiter_state == arb_ifu_read && ifu_state_time == 0) begin
            ifu_state_time = $time;
        end
        if (arbiter_state == arb_lsu_write && wr_state_time == 0) begin
            wr_state_time = $time;
        end
    end

    initial begin
        #((num_transactions * 40 + 200) * clk_period);
        $display("Timeout: the test sequence did not finish in time");
        stop_with_failure();
    end

    initial begin
        int unsigned idx;
        int unsigned kind;
        void'($urandom(32'ha064_c140));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("arbiter_state", 32'(arb_idle), 32'(arbiter_state));
        check_value("ready_valid_outputs", 32'd0, 32'({ifu_arready, ifu_rvalid, mem_awready,
                    mem_wready, mem_bvalid, mem_arready, mem_rvalid}));
        check_value("ifu_rdata", 32'd0, ifu_rdata);
        check_value("mem_rdata", 32'd0, mem_rdata);

        write_word(mapped_addr(8'd5), 32'h1234_5678, 8'hFF);
        read_word(1'b0, mapped_addr(8'd5), 0);
        read_word(1'b1, mapped_addr(8'd5), 0);

        write_word(mapped_addr(8'd9), 32'hAABB_CCDD, 8'hFF);
        write_word(mapped_addr(8'd9), 32'h1122_3344, 8'hA5);    // Lanes 0 and 2 only
        read_word(1'b0, mapped_addr(8'd9), 2);

        // Fetch and store raised in the same cycle
        ifu_state_time = 0;
        wr_state_time  = 0;
        fork
            read_word(1'b1, mapped_addr(8'd9), 0);
            write_word(mapped_addr(8'd20), 32'hCAFE_F00D, 8'hFF);
        join
        check_value("arbiter_state order", 32'd1,
                    32'(ifu_state_time != 0 && ifu_state_time < wr_state_time));
        check_value("ifu_rvalid before mem_bvalid", 32'd1, 32'(ifu_resp_time < wr_resp_time));
        read_word(1'b0, mapped_addr(8'd20), 0);

        write_word(mapped_addr(8'd33), 32'h0BAD_F00D, 8'hFF);
        write_word(unmapped_addr(8'd33), 32'hFFFF_FFFF, 8'hFF);  // Same index, other page
        read_word(1'b0, unmapped_addr(8'd33), 1);
        read_word(1'b1, mapped_addr(8'd33), 0);

        repeat (num_random) begin
            idx  = $urandom % 16;               // Few words so reads hit written data
            kind = $urandom % 3;
            if (kind == 0) begin
                write_word(mapped_addr(8'(idx)), $urandom, 8'($urandom));
            end else begin
                // Long holds outlast the read latency
                read_word(kind == 1, mapped_addr(8'(idx)), int'($urandom % 12));
            end
        end

        repeat (3) @(posedge clk);
        check_value("response pulse count", req_count, resp_count);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/mem_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             ifu_arvalid,
    output wire                             ifu_arready,
    input  wire [bus_pkg::bus_addr_w-1:0]   ifu_araddr,
    output wire                             ifu_rvalid,
    input  wire                             ifu_rready,
    output wire [bus_pkg::bus_data_w-1:0]   ifu_rdata,

    input  wire                             mem_awvalid,
    output wire                             mem_awready,
    input  wire [bus_pkg::bus_addr_w-1:0]   mem_awaddr,
    input  wire                             mem_wvalid,
    output wire                             mem_wready,
    input  wire [bus_pkg::bus_data_w-1:0]   mem_wdata,
    input  wire [bus_pkg::bus_strb_w-1:0]   mem_wstrb,
    output wire                             mem_bvalid,
    input  wire                             mem_bready,
    input  wire                             mem_arvalid,
    output wire                             mem_arready,
    input  wire [bus_pkg::bus_addr_w-1:0]   mem_araddr,
    output wire                             mem_rvalid,
    input  wire                             mem_rready,
    output wire [bus_pkg::bus_data_w-1:0]   mem_rdata,

    output wire [bus_pkg::arb_state_w-1:0]  arbiter_state
);
    import bus_pkg::*;

    // Arbiter to slave channels
    wire                  awvalid_wire;
    wire                  awready_wire;
    wire [bus_addr_w-1:0] awaddr_wire;
    wire                  wvalid_wire;
    wire                  wready_wire;
    wire [bus_data_w-1:0] wdata_wire;
    wire [bus_strb_w-1:0] wstrb_wire;
    wire                  bvalid_wire;
    wire                  bready_wire;
    wire                  arvalid_wire;
    wire                  arready_wire;
    wire [bus_addr_w-1:0] araddr_wire;
    wire                  rvalid_wire;
    wire                  rready_wire;
    wire [bus_data_w-1:0] rdata_wire;

    bus_arbiter u_arbiter (
        .clk (clk), .rst (rst),
        .ifu_arvalid (ifu_arvalid), .ifu_arready (ifu_arready), .ifu_araddr (ifu_araddr),
        .ifu_rvalid (ifu_rvalid), .ifu_rready (ifu_rready), .ifu_rdata (ifu_rdata),
        .mem_awvalid (mem_awvalid), .mem_awready (mem_awready), .mem_awaddr (mem_awaddr),
        .mem_wvalid (mem_wvalid), .mem_wready (mem_wready),
        .mem_wdata (mem_wdata), .mem_wstrb (mem_wstrb),
        .mem_bvalid (mem_bvalid), .mem_bready (mem_bready),
        .mem_arvalid (mem_arvalid), .mem_arready (mem_arready), .mem_araddr (mem_araddr),
        .mem_rvalid (mem_rvalid), .mem_rready (mem_rready), .mem_rdata (mem_rdata),
        .awvalid_wire (awvalid_wire), .awready_wire (awready_wire),
        .awaddr_wire (awaddr_wire),
        .wvalid_wire (wvalid_wire), .wready_wire (wready_wire),
        .wdata_wire (wdata_wire), .wstrb_wire (wstrb_wire),
        .bvalid_wire (bvalid_wire), .bready_wire (bready_wire),
        .arvalid_wire (arvalid_wire), .arready_wire (arready_wire),
        .araddr_wire (araddr_wire),
        .rvalid_wire (rvalid_wire), .rready_wire (rready_wire), .rdata_wire (rdata_wire),
        .arbiter_state (arbiter_state)
    );

    sram_slave u_sram (
        .clk (clk), .rst (rst),
        .awvalid_wire (awvalid_wire), .awready_wire (awready_wire),
        .awaddr_wire (awaddr_wire),
        .wvalid_wire (wvalid_wire), .wready_wire (wready_wire),
        .wdata_wire (wdata_wire), .wstrb_wire (wstrb_wire),
        .bvalid_wire (bvalid_wire), .bready_wire (bready_wire),
        .arvalid_wire (arvalid_wire), .arready_wire (arready_wire),
        .araddr_wire (araddr_wire),
        .rvalid_wire (rvalid_wire), .rready_wire (rready_wire), .rdata_wire (rdata_wire)
    );

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             ifu_arvalid,
    output logic                            ifu_arready,
    input  wire [bus_pkg::bus_addr_w-1:0]   ifu_araddr,
    output logic                            ifu_rvalid,
    input  wire                             ifu_rready,
    output logic [bus_pkg::bus_data_w-1:0]  ifu_rdata,

    input  wire                             mem_awvalid,
    output logic                            mem_awready,
    input  wire [bus_pkg::bus_addr_w-1:0]   mem_awaddr,
    input  wire                             mem_wvalid,
    output logic                            mem_wready,
    input  wire [bus_pkg::bus_data_w-1:0]   mem_wdata,
    input  wire [bus_pkg::bus_strb_w-1:0]   mem_wstrb,
    output logic                            mem_bvalid,
    input  wire                             mem_bready,
    input  wire                             mem_arvalid,
    output logic                            mem_arready,
    input  wire [bus_pkg::bus_addr_w-1:0]   mem_araddr,
    output logic                            mem_rvalid,
    input  wire                             mem_rready,
    output logic [bus_pkg::bus_data_w-1:0]  mem_rdata,

    output logic                            awvalid_wire,
    input  wire                             awready_wire,
    output logic [bus_pkg::bus_addr_w-1:0]  awaddr_wire,
    output logic                            wvalid_wire,
    input  wire                             wready_wire,
    output logic [bus_pkg::bus_data_w-1:0]  wdata_wire,
    output logic [bus_pkg::bus_strb_w-1:0]  wstrb_wire,
    input  wire                             bvalid_wire,
    output logic                            bready_wire,
    output logic                            arvalid_wire,
    input  wire                             arready_wire,
    output logic [bus_pkg::bus_addr_w-1:0]  araddr_wire,
    input  wire                             rvalid_wire,
    output logic                            rready_wire,
    input  wire [bus_pkg::bus_data_w-1:0]   rdata_wire,

    output wire [bus_pkg::arb_state_w-1:0]  arbiter_state
);
    import bus_pkg::*;

    logic [arb_state_w-1:0] state;

    assign arbiter_state = state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= arb_idle;
            ifu_arready  <= 1'b0;
            ifu_rvalid   <= 1'b0;
            ifu_rdata    <= '0;
            mem_awready  <= 1'b0;
            mem_wready   <= 1'b0;
            mem_bvalid   <= 1'b0;
            mem_arready  <= 1'b0;
            mem_rvalid   <= 1'b0;
            mem_rdata    <= '0;
            awvalid_wire <= 1'b0;
            awaddr_wire  <= '0;
            wvalid_wire  <= 1'b0;
            wdata_wire   <= '0;
            wstrb_wire   <= '0;
            bready_wire  <= 1'b0;
            arvalid_wire <= 1'b0;
            araddr_wire  <= '0;
            rready_wire  <= 1'b0;
        end else begin
            // Nothing is forwarded unless an owner state drives it
            ifu_arready  <= 1'b0;
            ifu_rvalid   <= 1'b0;
            ifu_rdata    <= '0;
            mem_awready  <= 1'b0;
            mem_wready   <= 1'b0;
            mem_bvalid   <= 1'b0;
            mem_arready  <= 1'b0;
            mem_rvalid   <= 1'b0;
            mem_rdata    <= '0;
            awvalid_wire <= 1'b0;
            awaddr_wire  <= '0;
            wvalid_wire  <= 1'b0;
            wdata_wire   <= '0;
            wstrb_wire   <= '0;
            bready_wire  <= 1'b0;
            arvalid_wire <= 1'b0;
            araddr_wire  <= '0;
            rready_wire  <= 1'b0;

            case (state)
                arb_idle: begin
                    if (ifu_arvalid) begin              // Fetch always wins
                        state <= arb_ifu_read;
                    end else if (mem_awvalid) begin
                        state <= arb_lsu_write;
                    end else if (mem_arvalid) begin
                        state <= arb_lsu_read;
                    end
                end
                arb_ifu_read: begin
                    arvalid_wire <= ifu_arvalid;
                    araddr_wire  <= ifu_araddr;
                    rready_wire  <= ifu_rready;
                    ifu_arready  <= arready_wire;
                    ifu_rvalid   <= rvalid_wire && ifu_rready;  // Single pulse to master
                    ifu_rdata    <= rdata_wire;
                    if (rvalid_wire && ifu_rready) begin
                        state <= arb_idle;
                    end
                end
                arb_lsu_write: begin
                    awvalid_wire <= mem_awvalid;
                    awaddr_wire  <= mem_awaddr;
                    wvalid_wire  <= mem_wvalid;
                    wdata_wire   <= mem_wdata;
                    wstrb_wire   <= mem_wstrb;
                    bready_wire  <= mem_bready;
                    mem_awready  <= awready_wire;
                    mem_wready   <= wready_wire;
                    mem_bvalid   <= bvalid_wire && mem_bready;
                    if (bvalid_wire && mem_bready) begin
                        state <= arb_idle;
                    end
                end
                default: begin                          // arb_lsu_read
                    arvalid_wire <= mem_arvalid;
                    araddr_wire  <= mem_araddr;
                    rready_wire  <= mem_rready;
                    mem_arready  <= arready_wire;
                    mem_rvalid   <= rvalid_wire && mem_rready;
                    mem_rdata    <= rdata_wire;
                    if (rvalid_wire && mem_rready) begin
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

module sram_slave (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             awvalid_wire,
    output logic                            awready_wire,
    input  wire [bus_pkg::bus_addr_w-1:0]   awaddr_wire,
    input  wire                             wvalid_wire,
    output logic                            wready_wire,
    input  wire [bus_pkg::bus_data_w-1:0]   wdata_wire,
    input  wire [bus_pkg::bus_strb_w-1:0]   wstrb_wire,
    output logic                            bvalid_wire,
    input  wire                             bready_wire,
    input  wire                             arvalid_wire,
    output logic                            arready_wire,
    input  wire [bus_pkg::bus_addr_w-1:0]   araddr_wire,
    output logic                            rvalid_wire,
    input  wire                             rready_wire,
    output logic [bus_pkg::bus_data_w-1:0]  rdata_wire
);
    import bus_pkg::*;
    import mem_pkg::*;

    logic [bus_data_w-1:0]  mem [mem_words];
    logic [slv_state_w-1:0] state;
    mem_addr_u              wr_addr;
    mem_addr_u              rd_addr_q;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   timer_start;
    logic [mem_timer_w-1:0] timer_load;
    logic                   timer_busy;
    logic                   timer_done;

    always_comb begin
        wr_addr.raw = awaddr_wire;
    end

    // Write has the edge when both kinds show up together
    assign wr_accept   = (state == slv_idle) && !timer_busy && awvalid_wire && wvalid_wire;
    assign rd_accept   = (state == slv_idle) && !timer_busy && arvalid_wire && !wr_accept;
    assign timer_start = wr_accept || rd_accept;
    assign timer_load  = wr_accept ? mem_write_latency : mem_read_latency;

    mem_delay_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (timer_start),
        .load  (timer_load),
        .busy  (timer_busy),
        .done  (timer_done)
    );

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_addr_q.raw <= araddr_wire;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_accept && wr_addr.fields.page == mem_base_page) begin
            for (int b = 0; b < bus_data_w / 8; b++) begin
                if (wstrb_wire[b]) begin            // Byte lanes 0 to 3 only
                    mem[wr_addr.fields.index][8*b +: 8] <= wdata_wire[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= slv_idle;
            awready_wire <= 1'b0;
            wready_wire  <= 1'b0;
            bvalid_wire  <= 1'b0;
            arready_wire <= 1'b0;
            rvalid_wire  <= 1'b0;
            rdata_wire   <= '0;
        end else begin
            awready_wire <= 1'b0;
            wready_wire  <= 1'b0;
            arready_wire <= 1'b0;
            case (state)
                slv_idle: begin
                    if (wr_accept) begin
                        awready_wire <= 1'b1;           // Address and data taken together
                        wready_wire  <= 1'b1;
                        state        <= slv_wr_wait;
                    end else if (rd_accept) begin
                        arready_wire <= 1'b1;
                        state        <= slv_rd_wait;
                    end
                end
                slv_rd_wait: begin
                    if (timer_done) begin
                        rvalid_wire <= 1'b1;
                        rdata_wire  <= (rd_addr_q.fields.page == mem_base_page) ?
                                       mem[rd_addr_q.fields.index] : mem_unmapped_data;
                        state       <= slv_rd_resp;
                    end
                end
                slv_rd_resp: begin
                    if (rready_wire) begin
                        rvalid_wire <= 1'b0;
                        state       <= slv_idle;
                    end
                end
                slv_wr_wait: begin
                    if (timer_done) begin
                        bvalid_wire <= 1'b1;
                        state       <= slv_wr_resp;
                    end
                end
                slv_wr_resp: begin
                    if (bready_wire) begin
                        bvalid_wire <= 1'b0;
                        state       <= slv_idle;
                    end
                end
                default: state <= slv_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/mem_delay_timer.sv
`timescale 1ns/10ps
`default_nettype none

module mem_delay_timer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire [mem_pkg::mem_timer_w-1:0]  load,
    output logic                            busy,
    output logic                            done
);
    import mem_pkg::*;

    logic [mem_timer_w-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                // Start requests are dropped while counting
                if (count > mem_timer_w'(1)) begin
                    count <= count - 1'b1;
                end else begin
                    count <= '0;
                    busy  <= 1'b0;
                    done  <= 1'b1;              // One cycle only
                end
            end else if (start) begin
                count <= load;
                busy  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int mem_words   = 256;
    localparam int mem_index_w = 8;    // log2 of mem_words
    localparam int mem_timer_w = 4;

    // Upper 22 address bits of the mapped window
    localparam logic [21:0] mem_base_page = 22'(32'h8000_0000 >> 10);

    localparam logic [mem_timer_w-1:0] mem_read_latency  = 4'd3;
    localparam logic [mem_timer_w-1:0] mem_write_latency = 4'd2;

    localparam logic [31:0] mem_unmapped_data = 32'hDEAD_BEEF;

    // Slave FSM encodings
    localparam int slv_state_w = 3;
    localparam logic [slv_state_w-1:0] slv_idle    = 3'd0;
    localparam logic [slv_state_w-1:0] slv_rd_wait = 3'd1;
    localparam logic [slv_state_w-1:0] slv_rd_resp = 3'd2;
    localparam logic [slv_state_w-1:0] slv_wr_wait = 3'd3;
    localparam logic [slv_state_w-1:0] slv_wr_resp = 3'd4;

    // One address seen either whole or split into page, word and byte
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [21:0]            page;
            logic [mem_index_w-1:0] index;
            logic [1:0]             offset;
        } fields;
    } mem_addr_u;

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int bus_addr_w  = 32;   // Byte address
    localparam int bus_data_w  = 32;
    localparam int bus_strb_w  = 8;    // Upper four bits carried but unused
    localparam int arb_state_w = 2;

    // Which master currently owns the shared memory port
    localparam logic [arb_state_w-1:0] arb_idle      = 2'd0;
    localparam logic [arb_state_w-1:0] arb_ifu_read  = 2'd1;
    localparam logic [arb_state_w-1:0] arb_lsu_write = 2'd2;
    localparam logic [arb_state_w-1:0] arb_lsu_read  = 2'd3;

endpackage

`default_nettype wire
